//--- all.f
+incdir+logic
logic/portal_pkg.sv
logic/portalFifo.sv
logic/portalReadPath.sv
logic/portalWritePath.sv
logic/portalRegs.sv
logic/portalBridge.sv
verification/portalBridge_properties.sv
verification/portalBridge_tb.sv

//--- Makefile
TOP = portalBridge_tb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -o Vtb
	@out="$$(./obj_dir/Vtb)"; echo "$$out"; echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- verification/portalBridge_tb.sv
`timescale 1ns/1ns
`include "portal_config.svh"

module portalBridge_tb;

  import portal_pkg::*;

  localparam int Timeout = 200;

  logic      CLK;
  logic      RST_N;
  logic      arValid;
  logic      arReady;
  logic      rValid;
  logic      rReady = 1'b0;
  logic      awValid;
  logic      awReady;
  logic      wValid;
  logic      wReady;
  logic      bValid;
  logic      bReady = 1'b0;
  logic      indDeq;
  logic      indNotEmpty = 1'b0;
  logic      reqEnq;
  logic      reqNotFull;
  logic      interrupt;
  busAddr_t  arReq;
  busAddr_t  awReq;
  busRead_t  rBeat;
  busWrite_t wBeat;
  busId_t    bId;
  word_t     indData = '0;
  word_t     reqData;
  word_t     indPending;
  word_t     reqPending;

  integer   seed = 12;
  int       errors = 0;
  int       checks = 0;
  logic     holdR = 1'b0;
  logic     indEn;
  logic     reqEn;
  busRead_t rGot[$];
  busId_t   bGot[$];
  word_t    reqSeen[$];
  word_t    indQ[3];
  int       indCount = 0;
  int       deqPulses = 0;
  int       expHead = 0;

  portalBridge i_dut (.*);

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // ready lines and the indication queue model
  always @(negedge CLK) begin
    rReady = !holdR && (($random(seed) & 3) != 0);
    bReady = ($random(seed) & 3) != 0;
    indNotEmpty = deqPulses < indCount;
    indData = indNotEmpty ? indQ[deqPulses] : '0;
  end

  always @(posedge CLK) begin
    if (RST_N) begin
      if (rValid && rReady) rGot.push_back(rBeat);
      if (bValid && bReady) bGot.push_back(bId);
      if (reqEnq) reqSeen.push_back(reqData);
      if (indDeq) deqPulses++;
    end
  end

  task automatic abortRun(input string what);
    errors++;
    $display("%s", what);
    $display("CHECKS FAILED");
    $finish;
  endtask

  task automatic checkWord(input word_t got, input word_t exp, input string what);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // expected read word from the register map
  function automatic word_t modelWord(input logic req, input logic ctrl, input offset_t off);
    word_t pend;
    logic  en;
    pend = req ? reqPending : indPending;
    en   = req ? reqEn : indEn;
    if (ctrl) begin
      if (off[1:0] != 2'b00) return 32'h005A05A0;
      case (off[4:2])
        3'd0: return word_t'(pend != '0);
        3'd1: return word_t'(en);
        3'd2: return 32'd1;
        3'd3: return pend;
        3'd4: return req ? 32'd6 : 32'd5;
        3'd5: return 32'd2;
        default: return '0;
      endcase
    end
    if (off == 5'h04) return req ? word_t'(reqNotFull) : word_t'(expHead < indCount);
    if (!req && off == 5'h00 && expHead < indCount) return indQ[expHead];
    return '0;
  endfunction

  // ch 0 selects ar, 1 aw and 2 w
  task automatic waitReady(input int ch);
    int   t;
    logic rdy;
    t = 0;
    do begin
      @(posedge CLK);
      t++;
      rdy = (ch == 0) ? arReady : (ch == 1) ? awReady : wReady;
    end while (!rdy && t < Timeout);
    if (!rdy) abortRun("timeout: a bus channel never became ready");
    @(negedge CLK);
  endtask

  task automatic runRead(input logic req, input logic ctrl, input offset_t off,
                         input int len, input int hold);
    busId_t  id;
    offset_t o;
    int      t;
    int      i;
    id = busId_t'($random(seed));
    rGot.delete();
    holdR = (hold > 0);
    @(negedge CLK);
    arReq.addr = {req, ctrl ? 7'h00 : 7'h01, off};
    arReq.len  = len[3:0];
    arReq.id   = id;
    arValid    = 1'b1;
    waitReady(0);
    arValid = 1'b0;
    if (hold > 0) begin
      repeat (hold) @(negedge CLK);
      checkWord(word_t'(rValid), 32'd1, "rValid while rReady held low");
      holdR = 1'b0;
    end
    t = 0;
    while (rGot.size() < len + 1 && t < Timeout) begin
      @(negedge CLK);
      t++;
    end
    if (rGot.size() < len + 1) abortRun("timeout: read beats did not arrive");
    o = off;
    for (i = 0; i <= len; i++) begin
      checkWord(rGot[i].data, modelWord(req, ctrl, o), "read data");
      if (!req && !ctrl && o == 5'h00 && expHead < indCount) expHead++;
      checkWord(word_t'(rGot[i].id), word_t'(id), "read id");
      checkWord(word_t'(rGot[i].last), word_t'(i == len), "read last flag");
      o = o + 5'd4;
    end
  endtask

  task automatic runWrite(input logic req, input logic ctrl, input offset_t off,
                          input word_t words[4], input int n);
    busId_t id;
    int     t;
    int     i;
    id = busId_t'($random(seed));
    bGot.delete();
    awReq.addr = {req, ctrl ? 7'h00 : 7'h01, off};
    awReq.len  = 4'(n - 1);
    awReq.id   = id;
    awValid    = 1'b1;
    waitReady(1);
    awValid = 1'b0;
    for (i = 0; i < n; i++) begin
      wBeat.data = words[i];
      wBeat.last = (i == n - 1);
      wValid     = 1'b1;
      waitReady(2);
      wValid = 1'b0;
    end
    t = 0;
    while (bGot.size() == 0 && t < Timeout) begin
      @(negedge CLK);
      t++;
    end
    if (bGot.size() == 0) abortRun("timeout: no write response");
    checkWord(word_t'(bGot[0]), word_t'(id), "write response id");
  endtask

  initial begin
    word_t words[4];
    int    i;
    RST_N      = 1'b0;
    arValid    = 1'b0;
    awValid    = 1'b0;
    wValid     = 1'b0;
    arReq      = '0;
    awReq      = '0;
    wBeat      = '0;
    reqNotFull = 1'b1;
    indPending = 32'h0000_0300;
    reqPending = '0;
    indEn      = 1'b0;
    reqEn      = 1'b0;
    words      = '{default: '0};
    repeat (4) @(negedge CLK);
    RST_N = 1'b1;
    @(negedge CLK);

    // control tables and an unaligned offset
    runRead(1'b0, 1'b1, 5'h00, 7, 0);
    runRead(1'b1, 1'b1, 5'h00, 7, 0);
    runRead(1'b0, 1'b1, 5'h02, 0, 0);

    words[0] = 32'd1;
    runWrite(1'b0, 1'b1, 5'h04, words, 1);
    indEn = 1'b1;
    checkWord(word_t'(interrupt), 32'd1, "interrupt after enable");
    runRead(1'b0, 1'b1, 5'h04, 0, 0);
    words[0] = 32'd0;
    runWrite(1'b0, 1'b1, 5'h04, words, 1);
    indEn = 1'b0;
    checkWord(word_t'(interrupt), 32'd0, "interrupt after disable");
    runRead(1'b0, 1'b1, 5'h04, 0, 0);

    // three queued indications and one read too many
    indQ = '{32'hA1B2_C3D4, 32'h0BAD_F00D, 32'h1234_5678};
    indCount = 3;
    @(negedge CLK);
    repeat (4) runRead(1'b0, 1'b0, 5'h00, 0, 0);
    checkWord(word_t'(deqPulses), 32'd3, "indDeq pulse count");

    for (i = 0; i < 4; i++) words[i] = $random(seed);
    reqSeen.delete();
    runWrite(1'b1, 1'b0, 5'h00, words, 4);
    checkWord(word_t'(reqSeen.size()), 32'd4, "reqEnq count");
    for (i = 0; i < 4 && i < reqSeen.size(); i++) checkWord(reqSeen[i], words[i], "reqData");

    reqNotFull = 1'b0;
    reqSeen.delete();
    fork
      runWrite(1'b1, 1'b0, 5'h08, words, 4);
      begin
        repeat (20) @(negedge CLK);
        checkWord(word_t'(reqSeen.size() + bGot.size()), '0, "activity while full");
        reqNotFull = 1'b1;
      end
    join
    checkWord(word_t'(reqSeen.size()), 32'd4, "reqEnq count after release");
    for (i = 0; i < 4 && i < reqSeen.size(); i++) checkWord(reqSeen[i], words[i], "reqData");

    // long burst against a stalled r channel
    runRead(1'b0, 1'b1, 5'h00, 15, 40);

    errors += i_dut.i_props.failCount;
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- verification/portalBridge_properties.sv
`timescale 1ns/1ns

module portalBridge_properties (
  input logic                 CLK,
  input logic                 RST_N,
  input logic                 rValid,
  input logic                 rReady,
  input portal_pkg::busRead_t rBeat,
  input logic                 bValid,
  input logic                 bReady,
  input portal_pkg::busId_t   bId,
  input logic                 indDeq,
  input logic                 indNotEmpty,
  input logic                 reqEnq,
  input logic                 reqNotFull,
  input logic                 interrupt
);

  int failCount = 0;

  rHold: assert property (@(posedge CLK) disable iff (!RST_N)
    rValid && !rReady |=> rValid && $stable(rBeat))
    else begin
      failCount++;
      $error("r beat dropped or changed before it was taken");
    end

  bHold: assert property (@(posedge CLK) disable iff (!RST_N)
    bValid && !bReady |=> bValid && $stable(bId))
    else begin
      failCount++;
      $error("b response dropped or changed before it was taken");
    end

  // strobes only toward a ready portal
  deqGuard: assert property (@(posedge CLK) disable iff (!RST_N) indDeq |-> indNotEmpty)
    else begin
      failCount++;
      $error("indDeq with an empty indication queue");
    end

  enqGuard: assert property (@(posedge CLK) disable iff (!RST_N) reqEnq |-> reqNotFull)
    else begin
      failCount++;
      $error("reqEnq with a full request queue");
    end

  resetQuiet: assert property (@(posedge CLK) $rose(RST_N) |-> !rValid && !bValid && !interrupt)
    else begin
      failCount++;
      $error("outputs not low after reset");
    end

endmodule

bind portalBridge portalBridge_properties i_props (
  .CLK(CLK), .RST_N(RST_N),
  .rValid(rValid), .rReady(rReady), .rBeat(rBeat),
  .bValid(bValid), .bReady(bReady), .bId(bId),
  .indDeq(indDeq), .indNotEmpty(indNotEmpty),
  .reqEnq(reqEnq), .reqNotFull(reqNotFull), .interrupt(interrupt)
);

//--- logic/portalBridge.sv
`timescale 1ns/1ns

module portalBridge (
  input  logic                  CLK,
  input  logic                  RST_N,
  input  logic                  arValid,
  input  portal_pkg::busAddr_t  arReq,
  output logic                  arReady,
  output logic                  rValid,
  output portal_pkg::busRead_t  rBeat,
  input  logic                  rReady,
  input  logic                  awValid,
  input  portal_pkg::busAddr_t  awReq,
  output logic                  awReady,
  input  logic                  wValid,
  input  portal_pkg::busWrite_t wBeat,
  output logic                  wReady,
  output logic                  bValid,
  output portal_pkg::busId_t    bId,
  input  logic                  bReady,
  output logic                  indDeq,
  input  portal_pkg::word_t     indData,
  input  logic                  indNotEmpty,
  output logic                  reqEnq,
  output portal_pkg::word_t     reqData,
  input  logic                  reqNotFull,
  input  portal_pkg::word_t     indPending,
  input  portal_pkg::word_t     reqPending,
  output logic                  interrupt
);

  import portal_pkg::*;

  logic        rdStrobe;
  beatAccess_t rdAccess;
  word_t       rdWord;
  logic        wrValid;
  beatAccess_t wrAccess;
  word_t       wrData;
  logic        wrAccept;

  portalReadPath readPath (
    .CLK(CLK), .RST_N(RST_N),
    .arValid(arValid), .arReq(arReq), .arReady(arReady),
    .rValid(rValid), .rBeat(rBeat), .rReady(rReady),
    .rdStrobe(rdStrobe), .rdAccess(rdAccess), .rdWord(rdWord)
  );

  portalWritePath writePath (
    .CLK(CLK), .RST_N(RST_N),
    .awValid(awValid), .awReq(awReq), .awReady(awReady),
    .wValid(wValid), .wBeat(wBeat), .wReady(wReady),
    .bValid(bValid), .bId(bId), .bReady(bReady),
    .wrValid(wrValid), .wrAccess(wrAccess), .wrData(wrData), .wrAccept(wrAccept)
  );

  // both paths meet here, reads never stall writes
  portalRegs regs (
    .CLK(CLK), .RST_N(RST_N),
    .rdStrobe(rdStrobe), .rdAccess(rdAccess), .rdWord(rdWord),
    .wrValid(wrValid), .wrAccess(wrAccess), .wrData(wrData), .wrAccept(wrAccept),
    .indDeq(indDeq), .indData(indData), .indNotEmpty(indNotEmpty),
    .reqEnq(reqEnq), .reqData(reqData), .reqNotFull(reqNotFull),
    .indPending(indPending), .reqPending(reqPending), .interrupt(interrupt)
  );

endmodule

//--- logic/portalRegs.sv
`timescale 1ns/1ns
`include "portal_config.svh"

module portalRegs (
  input  logic                    CLK,
  input  logic                    RST_N,
  input  logic                    rdStrobe,
  input  portal_pkg::beatAccess_t rdAccess,
  output portal_pkg::word_t       rdWord,
  input  logic                    wrValid,
  input  portal_pkg::beatAccess_t wrAccess,
  input  portal_pkg::word_t       wrData,
  output logic                    wrAccept,
  output logic                    indDeq,
  input  portal_pkg::word_t       indData,
  input  logic                    indNotEmpty,
  output logic                    reqEnq,
  output portal_pkg::word_t       reqData,
  input  logic                    reqNotFull,
  input  portal_pkg::word_t       indPending,
  input  portal_pkg::word_t       reqPending,
  output logic                    interrupt
);

  import portal_pkg::*;

  logic  indIntrEn;
  logic  reqIntrEn;
  word_t pending;
  logic  enable;
  word_t ctrlWord;
  word_t dataWord;
  logic  reqDataWrite;
  logic  enableWrite;

  assign pending = rdAccess.req ? reqPending : indPending;
  assign enable  = rdAccess.req ? reqIntrEn : indIntrEn;

  always_comb begin
    case (rdAccess.offset)
      `PORTAL_OFF_STATUS:  ctrlWord = word_t'(pending != '0);
      `PORTAL_OFF_ENABLE:  ctrlWord = word_t'(enable);
      `PORTAL_OFF_ONE:     ctrlWord = word_t'(1);
      `PORTAL_OFF_PENDING: ctrlWord = pending;
      `PORTAL_OFF_KIND:    ctrlWord = word_t'(rdAccess.req ? `PORTAL_REQ_KIND : `PORTAL_IND_KIND);
      `PORTAL_OFF_VERSION: ctrlWord = word_t'(`PORTAL_VERSION);
      `PORTAL_OFF_RSVD0, `PORTAL_OFF_RSVD1: ctrlWord = '0;
      default:             ctrlWord = `PORTAL_BAD_OFFSET;
    endcase
  end

  // empty indication queue reads as zero, no stall
  always_comb begin
    dataWord = '0;
    if (!rdAccess.req) begin
      if (rdAccess.offset == `PORTAL_DATA_MSG && indNotEmpty) begin
        dataWord = indData;
      end else if (rdAccess.offset == `PORTAL_DATA_FLAG) begin
        dataWord = word_t'(indNotEmpty);
      end
    end else if (rdAccess.offset == `PORTAL_DATA_FLAG) begin
      dataWord = word_t'(reqNotFull);
    end
  end

  assign rdWord = rdAccess.ctrl ? ctrlWord : dataWord;
  assign indDeq = rdStrobe && !rdAccess.req && !rdAccess.ctrl &&
                  (rdAccess.offset == `PORTAL_DATA_MSG) && indNotEmpty;

  // request data waits for queue space
  assign reqDataWrite = wrAccess.req && !wrAccess.ctrl;
  assign wrAccept     = wrValid && (!reqDataWrite || reqNotFull);
  assign reqEnq       = wrAccept && reqDataWrite;
  assign reqData      = wrData;
  assign enableWrite  = wrAccept && wrAccess.ctrl && (wrAccess.offset == `PORTAL_OFF_ENABLE);

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      indIntrEn <= 1'b0;
      reqIntrEn <= 1'b0;
    end else if (enableWrite) begin
      if (wrAccess.req) begin
        reqIntrEn <= wrData[0];
      end else begin
        indIntrEn <= wrData[0];
      end
    end
  end

  assign interrupt = (indIntrEn && (indPending != '0)) || (reqIntrEn && (reqPending != '0));

endmodule

//--- logic/portalWritePath.sv
`timescale 1ns/1ns

module portalWritePath (
  input  logic                    CLK,
  input  logic                    RST_N,
  input  logic                    awValid,
  input  portal_pkg::busAddr_t    awReq,
  output logic                    awReady,
  input  logic                    wValid,
  input  portal_pkg::busWrite_t   wBeat,
  output logic                    wReady,
  output logic                    bValid,
  output portal_pkg::busId_t      bId,
  input  logic                    bReady,
  output logic                    wrValid,
  output portal_pkg::beatAccess_t wrAccess,
  output portal_pkg::word_t       wrData,
  input  logic                    wrAccept
);

  import portal_pkg::*;

  busAddr_t  awHead;
  logic      awHeadValid;
  logic      awPop;
  busWrite_t wHead;
  logic      wHeadValid;
  logic      wPop;
  logic      bRoom;
  logic      bPush;
  logic      beatDone;
  logic      midBurst;
  offset_t   curOffset;
  offset_t   beatOffset;

  portalFifo #(
    .payload_t(busAddr_t)
  ) awFifo (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .inValid  (awValid),
    .inData   (awReq),
    .inReady  (awReady),
    .outValid (awHeadValid),
    .outData  (awHead),
    .outReady (awPop)
  );

  portalFifo #(
    .payload_t(busWrite_t)
  ) wFifo (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .inValid  (wValid),
    .inData   (wBeat),
    .inReady  (wReady),
    .outValid (wHeadValid),
    .outData  (wHead),
    .outReady (wPop)
  );

  assign beatOffset = midBurst ? curOffset : awHead.addr[4:0];

  // last beat waits for room in the response queue
  assign wrValid  = awHeadValid && wHeadValid && (!wHead.last || bRoom);
  assign wrAccess = makeAccess(awHead, beatOffset);
  assign wrData   = wHead.data;

  assign beatDone = wrValid && wrAccept;
  assign wPop     = beatDone;
  assign awPop    = beatDone && wHead.last;
  assign bPush    = beatDone && wHead.last;

  portalFifo #(
    .payload_t(busId_t)
  ) bFifo (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .inValid  (bPush),
    .inData   (awHead.id),
    .inReady  (bRoom),
    .outValid (bValid),
    .outData  (bId),
    .outReady (bReady)
  );

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      midBurst  <= 1'b0;
      curOffset <= '0;
    end else if (beatDone) begin
      if (wHead.last) begin
        midBurst <= 1'b0;
      end else begin
        midBurst  <= 1'b1;
        curOffset <= nextOffset(beatOffset);
      end
    end
  end

endmodule

//--- logic/portalReadPath.sv
`timescale 1ns/1ns
`include "portal_config.svh"

module portalReadPath (
  input  logic                    CLK,
  input  logic                    RST_N,
  input  logic                    arValid,
  input  portal_pkg::busAddr_t    arReq,
  output logic                    arReady,
  output logic                    rValid,
  output portal_pkg::busRead_t    rBeat,
  input  logic                    rReady,
  output logic                    rdStrobe,
  output portal_pkg::beatAccess_t rdAccess,
  input  portal_pkg::word_t       rdWord
);

  import portal_pkg::*;

  busAddr_t                 head;
  logic                     headValid;
  logic                     headPop;
  busRead_t                 rPush;
  logic                     rRoom;
  logic                     midBurst;
  logic [`PORTAL_LEN_W-1:0] beatCnt;
  offset_t                  curOffset;
  offset_t                  beatOffset;
  logic                     lastBeat;

  portalFifo #(
    .payload_t(busAddr_t)
  ) arFifo (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .inValid  (arValid),
    .inData   (arReq),
    .inReady  (arReady),
    .outValid (headValid),
    .outData  (head),
    .outReady (headPop)
  );

  // first beat takes the offset from the request itself
  assign beatOffset = midBurst ? curOffset : head.addr[`PORTAL_OFFSET_W-1:0];
  assign lastBeat   = (beatCnt == head.len);

  // one beat per cycle while the return queue has room
  assign rdStrobe = headValid && rRoom;
  assign rdAccess = makeAccess(head, beatOffset);
  assign headPop  = rdStrobe && lastBeat;

  assign rPush.data = rdWord;
  assign rPush.id   = head.id;
  assign rPush.last = lastBeat;

  portalFifo #(
    .payload_t(busRead_t)
  ) rFifo (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .inValid  (rdStrobe),
    .inData   (rPush),
    .inReady  (rRoom),
    .outValid (rValid),
    .outData  (rBeat),
    .outReady (rReady)
  );

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      midBurst  <= 1'b0;
      beatCnt   <= '0;
      curOffset <= '0;
    end else if (rdStrobe) begin
      if (lastBeat) begin
        midBurst <= 1'b0;
        beatCnt  <= '0;
      end else begin
        midBurst  <= 1'b1;
        beatCnt   <= beatCnt + 1'b1;
        curOffset <= nextOffset(beatOffset);
      end
    end
  end

endmodule

//--- logic/portalFifo.sv
`timescale 1ns/1ns
`include "portal_config.svh"

module portalFifo #(
  parameter type payload_t = logic
) (
  input  logic     CLK,
  input  logic     RST_N,
  input  logic     inValid,
  input  payload_t inData,
  output logic     inReady,
  output logic     outValid,
  output payload_t outData,
  input  logic     outReady
);

  localparam int Depth = `PORTAL_FIFO_DEPTH;
  localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;

  payload_t mem [Depth];

  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [PtrW:0]   count;
  logic            push;
  logic            pop;

  assign inReady  = (count != (PtrW + 1)'(Depth));
  assign outValid = (count != '0);
  assign outData  = mem[rdPtr];

  assign push = inValid && inReady;
  assign pop  = outValid && outReady;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
      end
      count <= count + (PtrW + 1)'(push) - (PtrW + 1)'(pop);
    end
  end

  // storage only, no reset
  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wrPtr] <= inData;
    end
  end

endmodule

//--- logic/portal_pkg.sv
`include "portal_config.svh"

package portal_pkg;

  typedef logic [`PORTAL_DATA_W-1:0]   word_t;
  typedef logic [`PORTAL_ID_W-1:0]     busId_t;
  typedef logic [`PORTAL_OFFSET_W-1:0] offset_t;

  // burst request, bit 12 of addr picks the portal
  typedef struct packed {
    logic [`PORTAL_ADDR_W-1:0] addr;
    logic [`PORTAL_LEN_W-1:0]  len;
    busId_t                    id;
  } busAddr_t;

  typedef struct packed {
    word_t  data;
    busId_t id;
    logic   last;
  } busRead_t;

  typedef struct packed {
    word_t data;
    logic  last;
  } busWrite_t;

  // one register access, req set for the request portal
  typedef struct packed {
    logic    req;
    logic    ctrl;
    offset_t offset;
  } beatAccess_t;

  function automatic beatAccess_t makeAccess(input busAddr_t burst, input offset_t offset);
    beatAccess_t acc;
    acc.req    = burst.addr[`PORTAL_ADDR_W-1];
    acc.ctrl   = (burst.addr[`PORTAL_ADDR_W-2:`PORTAL_OFFSET_W] == '0);
    acc.offset = offset;
    return acc;
  endfunction

  // wraps inside the 5-bit offset
  function automatic offset_t nextOffset(input offset_t offset);
    return offset + offset_t'(`PORTAL_BEAT_BYTES);
  endfunction

endpackage

//--- logic/portal_config.svh
`ifndef PORTAL_CONFIG_SVH
`define PORTAL_CONFIG_SVH

`define PORTAL_DATA_W     32
`define PORTAL_ID_W       6
`define PORTAL_OFFSET_W   5
`define PORTAL_LEN_W      4
`define PORTAL_ADDR_W     13
`define PORTAL_FIFO_DEPTH 2
`define PORTAL_BEAT_BYTES 4

// identity words of the control space
`define PORTAL_IND_KIND   5
`define PORTAL_REQ_KIND   6
`define PORTAL_VERSION    2
`define PORTAL_BAD_OFFSET 32'h005A05A0

// control space offsets
`define PORTAL_OFF_STATUS  5'h00
`define PORTAL_OFF_ENABLE  5'h04
`define PORTAL_OFF_ONE     5'h08
`define PORTAL_OFF_PENDING 5'h0C
`define PORTAL_OFF_KIND    5'h10
`define PORTAL_OFF_VERSION 5'h14
`define PORTAL_OFF_RSVD0   5'h18
`define PORTAL_OFF_RSVD1   5'h1C

// data space offsets
`define PORTAL_DATA_MSG    5'h00
`define PORTAL_DATA_FLAG   5'h04

`endif
